// File: logic/xlr8_cfg.svh
// Widths, register map and divider counts
// for the I/O fabric of the 16 MHz board design
`ifndef XLR8_CFG_SVH
`define XLR8_CFG_SVH

//////////////////////////////
// Widths
//////////////////////////////
`define XLR8_NUM_PINS      20       // D13..D0 and A5..A0
`define XLR8_DATA_W        8        // Register bus data
`define XLR8_ADR_W         8        // Low byte of data memory address

//////////////////////////////
// Register addresses
//////////////////////////////
`define XLR8_PINB_ADDR     8'h23    // Read only
`define XLR8_DDRB_ADDR     8'h24
`define XLR8_PORTB_ADDR    8'h25
`define XLR8_PINC_ADDR     8'h26    // Read only
`define XLR8_DDRC_ADDR     8'h27
`define XLR8_PORTC_ADDR    8'h28
`define XLR8_PIND_ADDR     8'h29    // Read only
`define XLR8_DDRD_ADDR     8'h2A
`define XLR8_PORTD_ADDR    8'h2B
`define XLR8_GPIOR0_ADDR   8'h3E
`define XLR8_GPIOR1_ADDR   8'h4A
`define XLR8_GPIOR2_ADDR   8'h4B
`define XLR8_CLKSPD_ADDR   8'hE0    // Read only clock config
`define XLR8_XBCTRL_ADDR   8'hE1    // Accelerator control

// 8 means 16 MHz build
`define XLR8_DESIGN_CONFIG 8'd8

//////////////////////////////
// Divider counts at 16 MHz
//////////////////////////////
`define XLR8_DIV_1MHZ      16       // 16 MHz / 16
`define XLR8_DIV_128KHZ    125      // 16 MHz / 125
`define XLR8_DIV_INTOSC    512      // Half period of div1024 wave

`define XLR8_OVR_PIN       8        // PB0 in pin numbering

`endif

// File: logic/xlr8_pkg.sv
// Shared types of the I/O fabric
// Register bus, pin control, pin override and clock enables
`include "xlr8_cfg.svh"

package xlr8_pkg;

  //////////////////////////////
  // Scalar vectors
  //////////////////////////////
  typedef logic [`XLR8_NUM_PINS-1:0] pin_vec_t;  // One bit per pin
  typedef logic [`XLR8_DATA_W-1:0]   data_t;     // Bus data byte

  // Data memory register bus from the master
  typedef struct packed {
    logic [`XLR8_ADR_W-1:0]  ramadr;  // Low address byte
    logic                    ramre;   // Read strobe
    logic                    ramwe;   // Write strobe
    logic [`XLR8_DATA_W-1:0] dbus_in; // Write data
  } io_bus_t;

  // Port registers or override values
  typedef struct packed {
    pin_vec_t val;  // Output value
    pin_vec_t dir;  // 1 means output
  } pin_ctrl_t;

  // Override enables, one per pin
  typedef struct packed {
    pin_vec_t ddoe;  // Direction override enable
    pin_vec_t pvoe;  // Value override enable
  } pin_ovr_t;

  // Timer outputs
  typedef struct packed {
    logic en1mhz;    // One cycle every 16
    logic en128khz;  // One cycle every 125
    logic div1024;   // Square wave
  } clk_en_t;

endpackage

// File: logic/xlr8_clk_en.sv
// Free running clock enable timer
// 1 MHz and 128 kHz single cycle strobes
// Divide by 1024 square wave for the override pin
`timescale 1ns/1ps
`include "xlr8_cfg.svh"

module xlr8_clk_en
  import xlr8_pkg::*;
(
  input  logic    Clock,   // 16 MHz
  input  logic    reset,   // Sync, active high
  output clk_en_t clk_en   // Strobes and wave
);

  localparam int CNT1_W  = $clog2(`XLR8_DIV_1MHZ);
  localparam int CNT128_W = $clog2(`XLR8_DIV_128KHZ);
  localparam int CNTOSC_W = $clog2(`XLR8_DIV_INTOSC);

  logic [CNT1_W-1:0]   cnt_1mhz;    // 0..15
  logic [CNT128_W-1:0] cnt_128khz;  // 0..124
  logic [CNTOSC_W-1:0] cnt_osc;     // 0..511
  logic                wrap_1mhz;
  logic                wrap_128khz;
  logic                wrap_osc;
  logic                div1024_q;

  //////////////////////////////
  // Terminal counts
  //////////////////////////////
  assign wrap_1mhz   = (cnt_1mhz == CNT1_W'(`XLR8_DIV_1MHZ - 1));
  assign wrap_128khz = (cnt_128khz == CNT128_W'(`XLR8_DIV_128KHZ - 1));
  assign wrap_osc    = (cnt_osc == CNTOSC_W'(`XLR8_DIV_INTOSC - 1));

  // 1 MHz divider
  always_ff @(posedge Clock) begin
    if (reset) begin
      cnt_1mhz <= '0;
    end else if (wrap_1mhz) begin
      cnt_1mhz <= '0;              // Restart period
    end else begin
      cnt_1mhz <= cnt_1mhz + 1'b1;
    end
  end

  // 128 kHz divider
  always_ff @(posedge Clock) begin
    if (reset) begin
      cnt_128khz <= '0;
    end else if (wrap_128khz) begin
      cnt_128khz <= '0;            // Not a power of two
    end else begin
      cnt_128khz <= cnt_128khz + 1'b1;
    end
  end

  // Half period counter and wave flop
  always_ff @(posedge Clock) begin
    if (reset) begin
      cnt_osc   <= '0;
      div1024_q <= 1'b0;           // Wave starts low
    end else if (wrap_osc) begin
      cnt_osc   <= '0;
      div1024_q <= ~div1024_q;     // Toggle each 512 cycles
    end else begin
      cnt_osc   <= cnt_osc + 1'b1;
    end
  end

  //////////////////////////////
  // Outputs
  //////////////////////////////
  // Strobe in the last cycle of each period, so the first one lands
  // on cycle 16 and cycle 125 after reset
  assign clk_en.en1mhz   = wrap_1mhz;
  assign clk_en.en128khz = wrap_128khz;
  assign clk_en.div1024  = div1024_q;

endmodule

// File: logic/xlr8_io_regs.sv
// Memory mapped I/O registers
// PORTx and DDRx pairs, PINx reads, GPIOR0..2
// CLKSPD read only config and XBCTRL accelerator control
// Combinational read data multiplexer
`timescale 1ns/1ps
`include "xlr8_cfg.svh"

module xlr8_io_regs
  import xlr8_pkg::*;
(
  input  logic      Clock,      // 16 MHz
  input  logic      reset,      // Sync, active high
  input  io_bus_t   io_bus,     // From bus master
  input  pin_vec_t  pin_sync,   // Synchronized pins
  output data_t     rdata,      // Zero when not selected
  output logic      out_en,     // Read hit this cycle
  output pin_ctrl_t port_ctrl,  // To pin mux
  output logic      xb_en       // Override PB0 with wave
);

  data_t portb_q;   // Only [5:0] reach pins
  data_t ddrb_q;
  data_t portc_q;   // Only [5:0] reach pins
  data_t ddrc_q;
  data_t portd_q;
  data_t ddrd_q;
  data_t gpior0_q;
  data_t gpior1_q;
  data_t gpior2_q;
  logic  xbctrl_q;  // XBCTRL bit 0
  data_t rd_mux;
  logic  rd_hit;

  //////////////////////////////
  // Write decode
  //////////////////////////////
  always_ff @(posedge Clock) begin
    if (reset) begin
      portb_q  <= '0;
      ddrb_q   <= '0;             // All pins input
      portc_q  <= '0;
      ddrc_q   <= '0;
      portd_q  <= '0;
      ddrd_q   <= '0;
      gpior0_q <= '0;
      gpior1_q <= '0;
      gpior2_q <= '0;
      xbctrl_q <= 1'b0;           // Override off
    end else if (io_bus.ramwe) begin
      case (io_bus.ramadr)
        `XLR8_PORTB_ADDR:  portb_q  <= io_bus.dbus_in;
        `XLR8_DDRB_ADDR:   ddrb_q   <= io_bus.dbus_in;
        `XLR8_PORTC_ADDR:  portc_q  <= io_bus.dbus_in;
        `XLR8_DDRC_ADDR:   ddrc_q   <= io_bus.dbus_in;
        `XLR8_PORTD_ADDR:  portd_q  <= io_bus.dbus_in;
        `XLR8_DDRD_ADDR:   ddrd_q   <= io_bus.dbus_in;
        `XLR8_GPIOR0_ADDR: gpior0_q <= io_bus.dbus_in;
        `XLR8_GPIOR1_ADDR: gpior1_q <= io_bus.dbus_in;
        `XLR8_GPIOR2_ADDR: gpior2_q <= io_bus.dbus_in;
        `XLR8_XBCTRL_ADDR: xbctrl_q <= io_bus.dbus_in[0];
        default: ;                // PINx and CLKSPD ignore writes
      endcase
    end
  end

  //////////////////////////////
  // Read multiplexer
  //////////////////////////////
  always_comb begin
    rd_mux = '0;
    rd_hit = 1'b1;
    case (io_bus.ramadr)
      `XLR8_PINB_ADDR:   rd_mux = {2'b00, pin_sync[13:8]};   // PB5..PB0
      `XLR8_DDRB_ADDR:   rd_mux = ddrb_q;
      `XLR8_PORTB_ADDR:  rd_mux = portb_q;
      `XLR8_PINC_ADDR:   rd_mux = {2'b00, pin_sync[19:14]};  // PC5..PC0
      `XLR8_DDRC_ADDR:   rd_mux = ddrc_q;
      `XLR8_PORTC_ADDR:  rd_mux = portc_q;
      `XLR8_PIND_ADDR:   rd_mux = pin_sync[7:0];             // PD7..PD0
      `XLR8_DDRD_ADDR:   rd_mux = ddrd_q;
      `XLR8_PORTD_ADDR:  rd_mux = portd_q;
      `XLR8_GPIOR0_ADDR: rd_mux = gpior0_q;
      `XLR8_GPIOR1_ADDR: rd_mux = gpior1_q;
      `XLR8_GPIOR2_ADDR: rd_mux = gpior2_q;
      `XLR8_CLKSPD_ADDR: rd_mux = `XLR8_DESIGN_CONFIG;       // Fixed build value
      `XLR8_XBCTRL_ADDR: rd_mux = {7'b0, xbctrl_q};          // Upper bits read zero
      default:           rd_hit = 1'b0;                      // Not ours
    endcase
  end

  assign out_en = io_bus.ramre & rd_hit;
  assign rdata  = out_en ? rd_mux : '0;   // Quiet bus when idle

  //////////////////////////////
  // Pin control packing
  //////////////////////////////
  // Bits 7:0 port D, 13:8 port B, 19:14 port C
  assign port_ctrl.val = {portc_q[5:0], portb_q[5:0], portd_q};
  assign port_ctrl.dir = {ddrc_q[5:0], ddrb_q[5:0], ddrd_q};

  assign xb_en = xbctrl_q;

endmodule

// File: logic/xlr8_pin_mux.sv
// Pin multiplexer
// Accelerator override on PB0 combined with port registers
// Two flop input synchronizers for PINx reads
`timescale 1ns/1ps
`include "xlr8_cfg.svh"

module xlr8_pin_mux
  import xlr8_pkg::*;
(
  input  logic      Clock,      // 16 MHz
  input  logic      reset,      // Sync, active high
  input  pin_ctrl_t port_ctrl,  // PORTx and DDRx
  input  logic      xb_en,      // XBCTRL bit 0
  input  logic      div1024,    // Wave from timer
  input  pin_vec_t  pin_in,     // Async pin values
  output pin_vec_t  pin_out,    // Driven value
  output pin_vec_t  pin_oe,     // 1 drives the pin
  output pin_vec_t  pin_sync    // To PINx reads
);

  pin_ovr_t  ovr;       // Override enables
  pin_ctrl_t ovr_ctrl;  // Override values
  pin_vec_t  sync_q1;   // First stage

  //////////////////////////////
  // Override vectors
  //////////////////////////////
  // Wave goes to PB0 so input capture can time it
  assign ovr.ddoe     = pin_vec_t'(xb_en) << `XLR8_OVR_PIN;
  assign ovr.pvoe     = ovr.ddoe;
  assign ovr_ctrl.dir = '1;                                  // Force output
  assign ovr_ctrl.val = pin_vec_t'(div1024) << `XLR8_OVR_PIN;

  //////////////////////////////
  // Pin rule
  //////////////////////////////
  // Override wins bit by bit, else the port register
  assign pin_oe  = (ovr.ddoe & ovr_ctrl.dir) | (~ovr.ddoe & port_ctrl.dir);
  assign pin_out = (ovr.pvoe & ovr_ctrl.val) | (~ovr.pvoe & port_ctrl.val);

  //////////////////////////////
  // Input synchronizer
  //////////////////////////////
  always_ff @(posedge Clock) begin
    if (reset) begin
      sync_q1  <= '0;
      pin_sync <= '0;     // PINx reads zero after reset
    end else begin
      sync_q1  <= pin_in;
      pin_sync <= sync_q1;  // Two cycle latency
    end
  end

endmodule

// File: logic/xlr8_io_top.sv
// I/O fabric top level
// Clock enable timer, register block and pin multiplexer
`timescale 1ns/1ps

module xlr8_io_top
  import xlr8_pkg::*;
(
  input  logic     Clock,    // 16 MHz
  input  logic     reset,    // Sync, active high
  input  io_bus_t  io_bus,   // Register bus
  input  pin_vec_t pin_in,   // From pads
  output data_t    rdata,    // Read data
  output logic     out_en,   // Read hit
  output clk_en_t  clk_en,   // Strobes and wave
  output pin_vec_t pin_out,  // To pads
  output pin_vec_t pin_oe    // Pad drive enables
);

  pin_ctrl_t port_ctrl;  // PORTx and DDRx to pin mux
  logic      xb_en;      // Wave override on PB0
  pin_vec_t  pin_sync;   // Back to PINx reads

  //////////////////////////////
  // Timer
  //////////////////////////////
  xlr8_clk_en i_clk_en (
    .Clock  (Clock),
    .reset  (reset),
    .clk_en (clk_en)
  );

  //////////////////////////////
  // Registers
  //////////////////////////////
  xlr8_io_regs i_io_regs (
    .Clock     (Clock),
    .reset     (reset),
    .io_bus    (io_bus),
    .pin_sync  (pin_sync),
    .rdata     (rdata),
    .out_en    (out_en),
    .port_ctrl (port_ctrl),
    .xb_en     (xb_en)
  );

  //////////////////////////////
  // Pins
  //////////////////////////////
  xlr8_pin_mux i_pin_mux (
    .Clock     (Clock),
    .reset     (reset),
    .port_ctrl (port_ctrl),
    .xb_en     (xb_en),
    .div1024   (clk_en.div1024),  // Measured on PB0
    .pin_in    (pin_in),
    .pin_out   (pin_out),
    .pin_oe    (pin_oe),
    .pin_sync  (pin_sync)
  );

endmodule

// File: test/xlr8_io_tb.sv
// Testbench for the I/O fabric top level
// Table of bus, pin and wait steps applied in a loop
// Free running checks of the clock enable timer
// LFSR stimulus, value checker and watchdog
`timescale 1ns/1ps
`include "xlr8_cfg.svh"

module xlr8_io_tb
  import xlr8_pkg::*;
();

  localparam int OP_WR   = 0;  // Bus write
  localparam int OP_RD   = 1;  // Bus read, data column holds out_en
  localparam int OP_PIN  = 2;  // Drive pin_in
  localparam int OP_WAIT = 3;  // Idle for data cycles
  localparam int OP_OUT  = 4;  // Compare pin_out
  localparam int OP_OE   = 5;  // Compare pin_oe
  localparam int OP_OVR  = 6;  // PB0 carries the wave

  logic     clk;
  logic     reset;
  io_bus_t  io_bus;
  pin_vec_t pin_in;
  data_t    rdata;
  logic     out_en;
  clk_en_t  clk_en;
  pin_vec_t pin_out;
  pin_vec_t pin_oe;

  string       step_name[$];   // Test name per step
  int          step_op[$];
  logic [7:0]  step_addr[$];
  logic [31:0] step_data[$];   // Write data or port values
  logic [31:0] step_exp[$];    // Expected value
  logic [31:0] lfsr_state;
  logic        table_ready;
  int          cyc = 0;        // 1 is the first cycle out of reset

  xlr8_io_top i_dut (
    .Clock   (clk),
    .reset   (reset),
    .io_bus  (io_bus),
    .pin_in  (pin_in),
    .rdata   (rdata),
    .out_en  (out_en),
    .clk_en  (clk_en),
    .pin_out (pin_out),
    .pin_oe  (pin_oe)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  always @(posedge clk) begin
    if (reset) begin
      cyc <= 1;
    end else begin
      cyc <= cyc + 1;
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] nxt;
    nxt = state >> 1;
    if (state[0]) begin
      nxt = nxt ^ 32'hA300_0000;  // Galois taps
    end
    return nxt;
  endfunction

  // One LFSR step per bit taken
  task automatic rand_bits(input int nbits, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < nbits; i++) begin
      value      = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // Pin numbering: D on 7:0, B on 13:8, C on 19:14
  function automatic logic [31:0] pin_vector(input logic [7:0] c, input logic [7:0] b,
                                             input logic [7:0] d);
    return {12'b0, c[5:0], b[5:0], d};
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Fail %s expected %0h actual %0h", name, expected, actual);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic add_step(input string name, input int op, input logic [7:0] addr,
                          input logic [31:0] data, input logic [31:0] expected);
    step_name.push_back(name);
    step_op.push_back(op);
    step_addr.push_back(addr);
    step_data.push_back(data);
    step_exp.push_back(expected);
  endtask

  //////////////////////////////
  // Test table
  //////////////////////////////
  task automatic build_table();
    logic [7:0]  reg_addr [9];
    string       reg_name [9];
    logic [7:0]  reg_val [9];
    logic [31:0] r;
    logic [7:0]  pb, db, pc, dc, pd, dd;
    reg_addr = '{`XLR8_GPIOR0_ADDR, `XLR8_GPIOR1_ADDR, `XLR8_GPIOR2_ADDR,
                 `XLR8_PORTB_ADDR, `XLR8_DDRB_ADDR, `XLR8_PORTC_ADDR,
                 `XLR8_DDRC_ADDR, `XLR8_PORTD_ADDR, `XLR8_DDRD_ADDR};
    reg_name = '{"gpior0", "gpior1", "gpior2", "portb", "ddrb", "portc",
                 "ddrc", "portd", "ddrd"};
    // Reset values
    add_step("reset_gpior0", OP_RD, `XLR8_GPIOR0_ADDR, 1, 0);
    add_step("reset_xbctrl", OP_RD, `XLR8_XBCTRL_ADDR, 1, 0);
    add_step("reset_pin_out", OP_OUT, 0, 0, 0);
    add_step("reset_pin_oe", OP_OE, 0, 0, 0);
    // Write then read back each writable register
    for (int i = 0; i < 9; i++) begin
      rand_bits(8, r);
      reg_val[i] = r[7:0];
      add_step({"wr_", reg_name[i]}, OP_WR, reg_addr[i], r, 0);
      add_step({"rd_", reg_name[i]}, OP_RD, reg_addr[i], 1, {24'b0, r[7:0]});
    end
    add_step("rd_unmapped_30", OP_RD, 8'h30, 0, 0);  // Hole in the map
    add_step("rd_unmapped_ff", OP_RD, 8'hFF, 0, 0);
    add_step("rd_clkspd", OP_RD, `XLR8_CLKSPD_ADDR, 1, 8);
    rand_bits(8, r);
    add_step("wr_clkspd", OP_WR, `XLR8_CLKSPD_ADDR, r, 0);
    add_step("rd_clkspd_after_wr", OP_RD, `XLR8_CLKSPD_ADDR, 1, 8);
    // Port registers onto the pins
    pb = reg_val[3];
    db = reg_val[4];
    pc = reg_val[5];
    dc = reg_val[6];
    pd = reg_val[7];
    dd = reg_val[8];
    add_step("port_pin_out", OP_OUT, 0, 0, pin_vector(pc, pb, pd));
    add_step("port_pin_oe", OP_OE, 0, 0, pin_vector(dc, db, dd));
    // Pin inputs through the synchronizer
    for (int k = 0; k < 2; k++) begin
      rand_bits(20, r);
      add_step("set_pins", OP_PIN, 0, r, 0);
      add_step("sync_wait", OP_WAIT, 0, 2, 0);
      add_step("rd_pinb", OP_RD, `XLR8_PINB_ADDR, 1, {26'b0, r[13:8]});
      add_step("rd_pinc", OP_RD, `XLR8_PINC_ADDR, 1, {26'b0, r[19:14]});
      add_step("rd_pind", OP_RD, `XLR8_PIND_ADDR, 1, {24'b0, r[7:0]});
      add_step("wr_pind", OP_WR, `XLR8_PIND_ADDR, ~r, 0);  // Read only
      add_step("rd_pind_after_wr", OP_RD, `XLR8_PIND_ADDR, 1, {24'b0, r[7:0]});
    end
    // Wave override on PB0
    rand_bits(8, r);
    db = r[7:0] & 8'hFE;                                 // PB0 as input
    add_step("wr_ddrb_in", OP_WR, `XLR8_DDRB_ADDR, db, 0);
    rand_bits(8, r);
    pb = r[7:0] | 8'h01;                                 // PB0 high against low wave
    add_step("wr_portb", OP_WR, `XLR8_PORTB_ADDR, pb, 0);
    rand_bits(8, r);
    add_step("wr_xbctrl_on", OP_WR, `XLR8_XBCTRL_ADDR, r | 1, 0);
    add_step("rd_xbctrl_on", OP_RD, `XLR8_XBCTRL_ADDR, 1, 1);  // Upper bits zero
    add_step("ovr_ddr_in_a", OP_OVR, 0, pin_vector(pc, pb, pd), pin_vector(dc, db, dd));
    add_step("ovr_wait_a", OP_WAIT, 0, 300, 0);
    add_step("ovr_ddr_in_b", OP_OVR, 0, pin_vector(pc, pb, pd), pin_vector(dc, db, dd));
    db = db | 8'h01;                                     // PB0 as output
    add_step("wr_ddrb_out", OP_WR, `XLR8_DDRB_ADDR, db, 0);
    add_step("ovr_wait_b", OP_WAIT, 0, 300, 0);
    add_step("ovr_ddr_out_a", OP_OVR, 0, pin_vector(pc, pb, pd), pin_vector(dc, db, dd));
    add_step("ovr_wait_c", OP_WAIT, 0, 300, 0);
    add_step("ovr_ddr_out_b", OP_OVR, 0, pin_vector(pc, pb, pd), pin_vector(dc, db, dd));
    add_step("ovr_wait_d", OP_WAIT, 0, 300, 0);
    add_step("ovr_ddr_out_c", OP_OVR, 0, pin_vector(pc, pb, pd), pin_vector(dc, db, dd));
    db = db & 8'hFE;                                     // PB0 back to input
    add_step("wr_ddrb_in_off", OP_WR, `XLR8_DDRB_ADDR, db, 0);
    add_step("wr_xbctrl_off", OP_WR, `XLR8_XBCTRL_ADDR, 0, 0);
    add_step("rd_xbctrl_off", OP_RD, `XLR8_XBCTRL_ADDR, 1, 0);
    add_step("restore_pin_out", OP_OUT, 0, 0, pin_vector(pc, pb, pd));
    add_step("restore_pin_oe", OP_OE, 0, 0, pin_vector(dc, db, dd));
  endtask

  // Drive at the rising edge, check half a period later
  task automatic run_step(input int idx);
    io_bus_t  bus_drive;
    pin_vec_t mask8;
    logic     wave;
    bus_drive = '0;
    mask8     = pin_vec_t'(1) << `XLR8_OVR_PIN;
    @(posedge clk);
    if (step_op[idx] == OP_WR || step_op[idx] == OP_RD) begin
      bus_drive.ramadr  = step_addr[idx];
      bus_drive.ramwe   = (step_op[idx] == OP_WR);
      bus_drive.ramre   = (step_op[idx] == OP_RD);
      bus_drive.dbus_in = step_data[idx][7:0];
    end
    io_bus <= bus_drive;                     // Idle unless bus op
    if (step_op[idx] == OP_PIN) begin
      pin_in <= step_data[idx][19:0];
    end
    @(negedge clk);
    wave = ((cyc - 1) / `XLR8_DIV_INTOSC) % 2;  // Wave phase from cycle count
    case (step_op[idx])
      OP_RD: begin
        check_value({step_name[idx], "_rdata"}, step_exp[idx], {24'b0, rdata});
        check_value({step_name[idx], "_out_en"}, step_data[idx], {31'b0, out_en});
      end
      OP_OUT:  check_value(step_name[idx], step_exp[idx], {12'b0, pin_out});
      OP_OE:   check_value(step_name[idx], step_exp[idx], {12'b0, pin_oe});
      OP_OVR: begin
        check_value({step_name[idx], "_oe"}, step_exp[idx] | mask8, {12'b0, pin_oe});
        check_value({step_name[idx], "_out"},
                    (step_data[idx] & ~{12'b0, mask8}) | (wave ? mask8 : 32'b0),
                    {12'b0, pin_out});
      end
      OP_WAIT: repeat (step_data[idx] - 1) @(negedge clk);
      default: ;
    endcase
  endtask

  //////////////////////////////
  // Timer checks every cycle
  //////////////////////////////
  always @(negedge clk) begin
    if (!reset) begin
      check_value($sformatf("en1mhz_cycle_%0d", cyc),
                  (cyc % `XLR8_DIV_1MHZ == 0), clk_en.en1mhz);
      check_value($sformatf("en128khz_cycle_%0d", cyc),
                  (cyc % `XLR8_DIV_128KHZ == 0), clk_en.en128khz);
      check_value($sformatf("div1024_cycle_%0d", cyc),
                  ((cyc - 1) / `XLR8_DIV_INTOSC) % 2, clk_en.div1024);
    end
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    io_bus      = '0;
    pin_in      = '0;
    reset       = 1'b1;
    lfsr_state  = 32'hd8b5_3a31;
    table_ready = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    for (int i = 0; i < step_op.size(); i++) begin
      run_step(i);
    end
    $display("Simulation completed successfully");
    $finish;
  end

  // Watchdog sized from the table
  initial begin
    wait (table_ready);
    repeat (step_op.size() * 4 + 2200) @(posedge clk);
    $display("Error: watchdog expired before the test table finished");
    $display("Simulation failed");
    $fatal(1, "timeout");
  end

endmodule

// File: list.f
+incdir+logic
logic/xlr8_pkg.sv
logic/xlr8_clk_en.sv
logic/xlr8_io_regs.sv
logic/xlr8_pin_mux.sv
logic/xlr8_io_top.sv
test/xlr8_io_tb.sv
